// ==== tb.f ====
tinyriscv_pkg.sv
pc_reg.sv
ctrl.sv
regs.sv
if_id.sv
id.sv
ex.sv
tinyriscv.sv
tb_mem.sv
tb_tinyriscv.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_tinyriscv -f tb.f -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Verification failed" sim.log; then
    exit 1
fi
if ! grep -q "Verification passed" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0

// ==== tb_tinyriscv.sv ====
module tb_tinyriscv
    import tinyriscv_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    localparam addr_t JAL_ADDR   = 32'h90;
    localparam int    NUM_STORES = 15;

    logic clk;
    logic arst_n;
    addr_t pc_addr;
    inst_t pc_data;
    logic wb_cyc, wb_stb, wb_we, wb_ack;
    addr_t wb_adr;
    reg_t wb_dat_m, wb_dat_s;
    logic [3:0] wb_sel;
    reg_addr_t dbg_addr;
    reg_t dbg_wdata, dbg_rdata;
    logic dbg_we, dbg_halt, dbg_reset_pc;

    reg_t op_a, op_b;
    reg_t exp_data [16];
    logic exp_valid [16];
    int   prog_len;
    int   store_count;
    int   errors;
    int   timeouts;
    logic ok;

    tinyriscv u_dut (
        .clk_i(clk), .arst_n_i(arst_n),
        .rib_pc_addr_o(pc_addr), .rib_pc_data_i(pc_data),
        .wb_cyc_o(wb_cyc), .wb_stb_o(wb_stb), .wb_we_o(wb_we), .wb_adr_o(wb_adr),
        .wb_dat_o(wb_dat_m), .wb_sel_o(wb_sel), .wb_dat_i(wb_dat_s), .wb_ack_i(wb_ack),
        .dbg_reg_addr_i(dbg_addr), .dbg_reg_data_i(dbg_wdata), .dbg_reg_we_i(dbg_we),
        .dbg_reg_data_o(dbg_rdata), .dbg_halt_i(dbg_halt), .dbg_reset_pc_i(dbg_reset_pc)
    );

    tb_mem u_mem (
        .clk_i(clk), .arst_n_i(arst_n), .pc_addr_i(pc_addr), .pc_data_o(pc_data),
        .cyc_i(wb_cyc), .stb_i(wb_stb), .we_i(wb_we), .adr_i(wb_adr), .dat_i(wb_dat_m),
        .sel_i(wb_sel), .dat_o(wb_dat_s), .ack_o(wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic report_err(input string msg);
        errors++;
        $display("ERR %0t: %s", $time, msg);
    endtask

    // instruction encoders
    function automatic inst_t enc_r(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                    logic [2:0] f3, reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic inst_t enc_i(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                    reg_addr_t rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic inst_t enc_sw(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic inst_t enc_b(logic [12:0] imm, reg_addr_t rs2, reg_addr_t rs1,
                                    logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic inst_t enc_jal(logic [20:0] imm, reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    task automatic emit(input inst_t word);
        u_mem.rom[prog_len] = word;
        prog_len++;
    endtask

    task automatic emit_alu_store(input inst_t alu, input int slot, input reg_t value);
        emit(alu);
        emit(enc_sw(12'(slot * 4), 5'd3, 5'd0));
        exp_data[slot]  = value;
        exp_valid[slot] = 1'b1;
    endtask

    task automatic load_program();
        prog_len = 0;
        for (int i = 0; i < 16; i++) exp_valid[i] = 1'b0;
        emit_alu_store(enc_r(7'h00, 2, 1, 3'b000, 3), 0, op_a + op_b);
        emit_alu_store(enc_r(7'h20, 2, 1, 3'b000, 3), 1, op_a - op_b);
        emit_alu_store(enc_r(7'h00, 2, 1, 3'b111, 3), 2, op_a & op_b);
        emit_alu_store(enc_r(7'h00, 2, 1, 3'b110, 3), 3, op_a | op_b);
        emit_alu_store(enc_r(7'h00, 2, 1, 3'b100, 3), 4, op_a ^ op_b);
        emit_alu_store(enc_r(7'h00, 2, 1, 3'b010, 3), 5,
                       ($signed(op_a) < $signed(op_b)) ? 32'd1 : 32'd0);
        emit_alu_store(enc_i(12'hffb, 1, 3'b000, 3, OPC_OPIMM), 6, op_a - 32'd5);
        emit_alu_store(enc_i(12'h5a5, 1, 3'b111, 3, OPC_OPIMM), 7, op_a & 32'h5a5);
        emit_alu_store(enc_i(12'hf00, 1, 3'b110, 3, OPC_OPIMM), 8, op_a | 32'hffff_ff00);
        emit_alu_store(enc_i(12'h123, 1, 3'b100, 3, OPC_OPIMM), 9, op_a ^ 32'h123);
        emit_alu_store(enc_i(12'h000, 1, 3'b010, 3, OPC_OPIMM), 10,
                       ($signed(op_a) < 0) ? 32'd1 : 32'd0);
        emit_alu_store({20'habcde, 5'd3, OPC_LUI}, 11, 32'habcd_e000);
        emit(enc_i(12'h007, 1, 3'b000, 0, OPC_OPIMM));                      // addi x0, x1, 7
        emit(enc_sw(12'd48, 0, 0));                                        // x0 stays 0
        exp_data[12]  = 32'd0;
        exp_valid[12] = 1'b1;
        emit(enc_i(12'h000, 0, 3'b010, 6, OPC_LOAD));                      // lw x6, 0(x0)
        emit(enc_r(7'h00, 1, 6, 3'b000, 6));
        emit(enc_sw(12'd52, 6, 0));
        exp_data[13]  = op_a + op_b + op_a;
        exp_valid[13] = 1'b1;
        emit(enc_b(13'd8, 0, 0, 3'b000));                                  // beq over the next sw
        emit(enc_sw(12'd56, 1, 0));
        emit(enc_i(12'h000, 0, 3'b000, 7, OPC_OPIMM));
        emit(enc_i(12'h003, 0, 3'b000, 8, OPC_OPIMM));
        emit(enc_i(12'h001, 7, 3'b000, 7, OPC_OPIMM));                      // loop body
        emit(enc_b(13'h1ffc, 8, 7, 3'b001));                               // bne back by 4
        emit(enc_sw(12'd60, 7, 0));
        exp_data[15]  = 32'd3;
        exp_valid[15] = 1'b1;
        emit(enc_jal(21'd0, 9));                                           // spin at JAL_ADDR
        while (prog_len < 64) emit(NOP_INST);
    endtask

    // Wishbone classic, request must not move while waiting for ack
    property bus_stable;
        @(posedge clk) disable iff (!arst_n)
        (wb_cyc && wb_stb && !wb_ack) |=> (wb_cyc && wb_stb && $stable(wb_adr)
            && $stable(wb_dat_m) && $stable(wb_we) && $stable(pc_addr));
    endproperty
    bus_stable_chk: assert property (bus_stable)
        else report_err("bus request changed before ack");

    always @(negedge clk) begin
        if (arst_n) begin
            if (dbg_halt) begin
                halt_chk: assert (!wb_cyc && !wb_stb) else report_err("bus request while halted");
            end
            if (wb_cyc && wb_stb) begin
                sel_chk: assert (wb_sel == 4'hf) else report_err("bus access not a full word");
            end
            if (wb_cyc && wb_stb && wb_we && wb_ack) begin
                skip_chk: assert (wb_adr != 32'd56) else report_err("store skipped by beq ran");
                store_chk: assert (wb_adr < 32'd64 && exp_valid[wb_adr[5:2]]
                                   && wb_dat_m == exp_data[wb_adr[5:2]])
                    else report_err($sformatf("store to %h got %h", wb_adr, wb_dat_m));
                store_count++;
            end
        end
    end

    initial begin
        void'($urandom(35));
        arst_n       = 1'b0;
        dbg_halt     = 1'b1;
        dbg_reset_pc = 1'b0;
        dbg_addr     = '0;
        dbg_wdata    = '0;
        dbg_we       = 1'b0;
        errors       = 0;
        timeouts     = 0;
        store_count  = 0;
        op_a         = $urandom;
        op_b         = $urandom;
        load_program();

        repeat (10) @(posedge clk);
        #1 arst_n = 1'b1;
        @(negedge clk);
        reset_chk: assert (!wb_cyc && !wb_stb && !wb_we && pc_addr == RESET_PC)
            else report_err("state after reset is wrong");

        @(posedge clk);
        #1 dbg_addr = 5'd1;
        dbg_wdata = op_a;
        dbg_we    = 1'b1;
        @(posedge clk);
        #1 dbg_addr = 5'd2;
        dbg_wdata = op_b;
        @(posedge clk);
        #1 dbg_we = 1'b0;
        dbg_addr = 5'd1;
        #1;
        dbg_read_chk: assert (dbg_rdata == op_a)
            else report_err($sformatf("debug read of x1 gave %h", dbg_rdata));
        @(posedge clk);
        #1 dbg_halt = 1'b0;

        ok = 1'b0;
        for (int n = 0; n < 3000 && !ok; n++) begin
            @(posedge clk);
            ok = (store_count >= NUM_STORES);
        end
        if (!ok) begin
            timeouts++;
            $display("timeout: program did not finish its stores");
        end else begin
            ok = 1'b0;
            for (int n = 0; n < 100 && !ok; n++) begin
                @(negedge clk);
                ok = (pc_addr == JAL_ADDR);
            end
            if (!ok) begin
                timeouts++;
                $display("timeout: fetch never reached the final jal");
            end else begin
                // jal flush alternates fetch between the jal and the word after it
                for (int n = 0; n < 16; n++) begin
                    @(negedge clk);
                    spin_chk: assert (pc_addr == JAL_ADDR || pc_addr == JAL_ADDR + 32'd4)
                        else report_err($sformatf("fetch left the jal loop at %h", pc_addr));
                end
                count_chk: assert (store_count == NUM_STORES)
                    else report_err($sformatf("%0d stores seen", store_count));
                @(posedge clk);
                #1 dbg_addr = 5'd9;
                #1;
                link_chk: assert (dbg_rdata == JAL_ADDR + 32'd4)
                    else report_err($sformatf("link register holds %h", dbg_rdata));
            end
        end

        $display("errors: %0d value, %0d timeout", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== tb_mem.sv ====
module tb_mem
    import tinyriscv_pkg::*;
(
    input  logic       clk_i,
    input  logic       arst_n_i,
    input  addr_t      pc_addr_i,
    output inst_t      pc_data_o,
    input  logic       cyc_i,
    input  logic       stb_i,
    input  logic       we_i,
    input  addr_t      adr_i,
    input  reg_t       dat_i,
    input  logic [3:0] sel_i,
    output reg_t       dat_o,
    output logic       ack_o
);
    timeunit 1ns;
    timeprecision 100ps;

    inst_t      rom [64];  // filled by the testbench top
    reg_t       ram [64];
    logic [1:0] wait_q;    // wait states for the current access
    logic [1:0] cnt_q;

    initial begin
        for (int i = 0; i < 64; i++) begin
            ram[i] = 32'hdead_0000 + 32'(i * 4);
        end
    end

    assign pc_data_o = rom[pc_addr_i[7:2]];
    assign dat_o     = ram[adr_i[7:2]];
    assign ack_o     = cyc_i && stb_i && (cnt_q == wait_q);

    always @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt_q  <= '0;
            wait_q <= '0;
        end else if (ack_o) begin
            cnt_q  <= '0;
            wait_q <= 2'($urandom % 4);  // next access waits 0 to 3 cycles
        end else if (cyc_i && stb_i) begin
            cnt_q <= cnt_q + 2'd1;
        end
    end

    always @(posedge clk_i) begin
        if (ack_o && we_i && (sel_i == 4'hf)) begin
            ram[adr_i[7:2]] <= dat_i;
        end
    end

endmodule

// ==== tinyriscv.sv ====
module tinyriscv
    import tinyriscv_pkg::*;
(
    input  logic       clk_i,
    input  logic       arst_n_i,

    output addr_t      rib_pc_addr_o,   // fetch address
    input  inst_t      rib_pc_data_i,   // instruction, same cycle

    output logic       wb_cyc_o,
    output logic       wb_stb_o,
    output logic       wb_we_o,
    output addr_t      wb_adr_o,
    output reg_t       wb_dat_o,
    output logic [3:0] wb_sel_o,
    input  reg_t       wb_dat_i,
    input  logic       wb_ack_i,

    input  reg_addr_t  dbg_reg_addr_i,
    input  reg_t       dbg_reg_data_i,
    input  logic       dbg_reg_we_i,
    output reg_t       dbg_reg_data_o,
    input  logic       dbg_halt_i,
    input  logic       dbg_reset_pc_i
);

    hold_e     ctrl_hold;
    logic      ctrl_flush;
    logic      ctrl_jump;
    addr_t     ctrl_jump_addr;

    fetch_s    if_fetch;

    reg_addr_t id_raddr1;
    reg_addr_t id_raddr2;
    exec_s     id_exec;

    reg_t      regs_rdata1;
    reg_t      regs_rdata2;

    logic      ex_reg_we;
    reg_addr_t ex_reg_waddr;
    reg_t      ex_reg_wdata;
    logic      ex_jump;
    addr_t     ex_jump_addr;
    logic      ex_mem_hold;

    pc_reg u_pc_reg (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .hold_i        (ctrl_hold),
        .jump_i        (ctrl_jump),
        .jump_addr_i   (ctrl_jump_addr),
        .dbg_reset_pc_i(dbg_reset_pc_i),
        .pc_o          (rib_pc_addr_o)
    );

    ctrl u_ctrl (
        .jump_i        (ex_jump),
        .jump_addr_i   (ex_jump_addr),
        .mem_hold_i    (ex_mem_hold),
        .dbg_halt_i    (dbg_halt_i),
        .dbg_reset_pc_i(dbg_reset_pc_i),
        .hold_o        (ctrl_hold),
        .flush_o       (ctrl_flush),
        .jump_o        (ctrl_jump),
        .jump_addr_o   (ctrl_jump_addr)
    );

    regs u_regs (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .we_i      (ex_reg_we),
        .waddr_i   (ex_reg_waddr),
        .wdata_i   (ex_reg_wdata),
        .raddr1_i  (id_raddr1),
        .raddr2_i  (id_raddr2),
        .rdata1_o  (regs_rdata1),
        .rdata2_o  (regs_rdata2),
        .dbg_we_i  (dbg_reg_we_i),
        .dbg_addr_i(dbg_reg_addr_i),
        .dbg_data_i(dbg_reg_data_i),
        .dbg_data_o(dbg_reg_data_o)
    );

    if_id u_if_id (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .inst_i     (rib_pc_data_i),
        .inst_addr_i(rib_pc_addr_o),
        .hold_i     (ctrl_hold),
        .flush_i    (ctrl_flush),
        .fetch_o    (if_fetch)
    );

    id u_id (
        .fetch_i (if_fetch),
        .rdata1_i(regs_rdata1),
        .rdata2_i(regs_rdata2),
        .raddr1_o(id_raddr1),
        .raddr2_o(id_raddr2),
        .exec_o  (id_exec)
    );

    ex u_ex (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .exec_i     (id_exec),
        .halt_i     (dbg_halt_i),
        .wb_dat_i   (wb_dat_i),
        .wb_ack_i   (wb_ack_i),
        .reg_we_o   (ex_reg_we),
        .reg_waddr_o(ex_reg_waddr),
        .reg_wdata_o(ex_reg_wdata),
        .jump_o     (ex_jump),
        .jump_addr_o(ex_jump_addr),
        .mem_hold_o (ex_mem_hold),
        .wb_cyc_o   (wb_cyc_o),
        .wb_stb_o   (wb_stb_o),
        .wb_we_o    (wb_we_o),
        .wb_adr_o   (wb_adr_o),
        .wb_dat_o   (wb_dat_o),
        .wb_sel_o   (wb_sel_o)
    );

endmodule

// ==== ex.sv ====
module ex
    import tinyriscv_pkg::*;
(
    input  logic       clk_i,
    input  logic       arst_n_i,
    input  exec_s      exec_i,
    input  logic       halt_i,
    input  reg_t       wb_dat_i,
    input  logic       wb_ack_i,

    output logic       reg_we_o,
    output reg_addr_t  reg_waddr_o,
    output reg_t       reg_wdata_o,

    output logic       jump_o,
    output addr_t      jump_addr_o,
    output logic       mem_hold_o,

    output logic       wb_cyc_o,
    output logic       wb_stb_o,
    output logic       wb_we_o,
    output addr_t      wb_adr_o,
    output reg_t       wb_dat_o,
    output logic [3:0] wb_sel_o
);

    typedef enum logic {
        IDLE,
        WAIT
    } state_e;

    state_e state_q;
    state_e state_d;
    reg_t   alu_res;
    logic   mem_op;
    logic   bus_req;
    logic   taken;
    logic   ops_eq;

    always_comb begin
        case (exec_i.alu_op)
            ADD:     alu_res = exec_i.op_a + exec_i.op_b;
            SUB:     alu_res = exec_i.op_a - exec_i.op_b;
            AND:     alu_res = exec_i.op_a & exec_i.op_b;
            OR:      alu_res = exec_i.op_a | exec_i.op_b;
            XOR:     alu_res = exec_i.op_a ^ exec_i.op_b;
            SLT:     alu_res = {31'b0, $signed(exec_i.op_a) < $signed(exec_i.op_b)};
            PASS_B:  alu_res = exec_i.op_b;
            default: alu_res = '0;
        endcase
    end

    // branches compare rs1 against rs2
    assign ops_eq      = (exec_i.op_a == exec_i.op_b);
    assign taken       = exec_i.is_jal | (exec_i.is_branch & (ops_eq ^ exec_i.branch_ne));
    assign jump_o      = taken & !halt_i;
    assign jump_addr_o = exec_i.branch_tgt;

    // halt blocks new cycles, an access already on the bus runs to ack
    assign mem_op  = exec_i.is_load | exec_i.is_store;
    assign bus_req = mem_op & ((state_q == WAIT) | !halt_i);

    assign wb_cyc_o = bus_req;
    assign wb_stb_o = bus_req;
    assign wb_we_o  = bus_req & exec_i.is_store;
    assign wb_adr_o = alu_res;            // rs1 + offset
    assign wb_dat_o = exec_i.store_data;
    assign wb_sel_o = 4'b1111;            // word accesses only

    assign mem_hold_o = bus_req & !wb_ack_i;

    // if_id moves on at ack, so IDLE always sees a fresh instruction next
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: if (bus_req && !wb_ack_i) state_d = WAIT;
            WAIT: if (wb_ack_i || !mem_op)  state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        reg_waddr_o = exec_i.rd;
        reg_we_o    = exec_i.reg_we & !halt_i;
        reg_wdata_o = alu_res;
        if (exec_i.is_load) begin
            reg_we_o    = reg_we_o & bus_req & wb_ack_i;  // retire on ack
            reg_wdata_o = wb_dat_i;
        end else if (exec_i.is_jal) begin
            reg_wdata_o = exec_i.inst_addr + 32'd4;       // link address
        end
    end

endmodule

// ==== id.sv ====
module id
    import tinyriscv_pkg::*;
(
    input  fetch_s    fetch_i,
    input  reg_t      rdata1_i,
    input  reg_t      rdata2_i,
    output reg_addr_t raddr1_o,
    output reg_addr_t raddr2_o,
    output exec_s     exec_o
);

    inst_t   inst;
    opcode_t opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_t    imm_i;
    reg_t    imm_s;
    reg_t    imm_b;
    reg_t    imm_j;
    reg_t    imm_u;

    assign inst   = fetch_i.inst;
    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};

    // rs1/rs2 fields are read unconditionally, unused data is ignored
    assign raddr1_o = inst[19:15];
    assign raddr2_o = inst[24:20];

    always_comb begin
        exec_o            = '0;
        exec_o.inst_addr  = fetch_i.inst_addr;
        exec_o.op_a       = rdata1_i;
        exec_o.op_b       = rdata2_i;
        exec_o.store_data = rdata2_i;
        exec_o.rd         = inst[11:7];
        exec_o.alu_op     = ADD;
        exec_o.branch_tgt = fetch_i.inst_addr + ((opcode == OPC_JAL) ? imm_j : imm_b);

        if (fetch_i.valid) begin
            case (opcode)
                OPC_LUI: begin
                    exec_o.op_b   = imm_u;
                    exec_o.alu_op = PASS_B;
                    exec_o.reg_we = 1'b1;
                end
                OPC_OPIMM: begin
                    exec_o.op_b   = imm_i;
                    exec_o.reg_we = 1'b1;
                    case (funct3)
                        3'b000:  exec_o.alu_op = ADD;
                        3'b010:  exec_o.alu_op = SLT;
                        3'b100:  exec_o.alu_op = XOR;
                        3'b110:  exec_o.alu_op = OR;
                        3'b111:  exec_o.alu_op = AND;
                        default: exec_o.reg_we = 1'b0;  // shifts, sltiu: no-op
                    endcase
                end
                OPC_OP: begin
                    exec_o.reg_we = 1'b1;
                    case ({funct7, funct3})
                        10'b0000000_000: exec_o.alu_op = ADD;
                        10'b0100000_000: exec_o.alu_op = SUB;
                        10'b0000000_010: exec_o.alu_op = SLT;
                        10'b0000000_100: exec_o.alu_op = XOR;
                        10'b0000000_110: exec_o.alu_op = OR;
                        10'b0000000_111: exec_o.alu_op = AND;
                        default:         exec_o.reg_we = 1'b0;
                    endcase
                end
                OPC_LOAD: begin
                    if (funct3 == 3'b010) begin  // lw only
                        exec_o.op_b    = imm_i;
                        exec_o.is_load = 1'b1;
                        exec_o.reg_we  = 1'b1;
                    end
                end
                OPC_STORE: begin
                    if (funct3 == 3'b010) begin  // sw only
                        exec_o.op_b     = imm_s;
                        exec_o.is_store = 1'b1;
                    end
                end
                OPC_BRANCH: begin
                    if (funct3 == 3'b000 || funct3 == 3'b001) begin
                        exec_o.is_branch = 1'b1;
                        exec_o.branch_ne = funct3[0];
                    end
                end
                OPC_JAL: begin
                    exec_o.is_jal = 1'b1;
                    exec_o.reg_we = 1'b1;
                end
                default: ;  // anything else retires as a no-op
            endcase
        end
    end

endmodule

// ==== if_id.sv ====
module if_id
    import tinyriscv_pkg::*;
(
    input  logic   clk_i,
    input  logic   arst_n_i,
    input  inst_t  inst_i,
    input  addr_t  inst_addr_i,
    input  hold_e  hold_i,
    input  logic   flush_i,
    output fetch_s fetch_o
);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            fetch_o <= '{inst: NOP_INST, inst_addr: RESET_PC, valid: 1'b0};
        end else if (flush_i) begin
            // redirect, drop the wrong-path word
            fetch_o <= '{inst: NOP_INST, inst_addr: RESET_PC, valid: 1'b0};
        end else if (hold_i == PIPE) begin
            fetch_o <= fetch_o;
        end else begin
            fetch_o.inst      <= inst_i;
            fetch_o.inst_addr <= inst_addr_i;
            fetch_o.valid     <= 1'b1;
        end
    end

endmodule

// ==== regs.sv ====
module regs
    import tinyriscv_pkg::*;
(
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  logic      we_i,
    input  reg_addr_t waddr_i,
    input  reg_t      wdata_i,
    input  reg_addr_t raddr1_i,
    input  reg_addr_t raddr2_i,
    output reg_t      rdata1_o,
    output reg_t      rdata2_o,
    input  logic      dbg_we_i,
    input  reg_addr_t dbg_addr_i,
    input  reg_t      dbg_data_i,
    output reg_t      dbg_data_o
);

    reg_t regs_q [1:31];  // x0 is not stored
    logic core_wr;
    logic dbg_wr;

    assign core_wr = we_i && (waddr_i != '0);
    // core write wins when both hit the same register
    assign dbg_wr  = dbg_we_i && (dbg_addr_i != '0) && !(core_wr && (waddr_i == dbg_addr_i));

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else begin
            if (dbg_wr) begin
                regs_q[dbg_addr_i] <= dbg_data_i;
            end
            if (core_wr) begin
                regs_q[waddr_i] <= wdata_i;
            end
        end
    end

    // the writer is the instruction being decoded, so it reads the old value
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs_q[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs_q[raddr2_i];

    assign dbg_data_o = (dbg_addr_i == '0) ? '0 : regs_q[dbg_addr_i];

endmodule

// ==== ctrl.sv ====
module ctrl
    import tinyriscv_pkg::*;
(
    input  logic  jump_i,
    input  addr_t jump_addr_i,
    input  logic  mem_hold_i,
    input  logic  dbg_halt_i,
    input  logic  dbg_reset_pc_i,
    output hold_e hold_o,
    output logic  flush_o,
    output logic  jump_o,
    output addr_t jump_addr_o
);

    // bus wait and debug halt both freeze the whole front end
    always_comb begin
        hold_o = NONE;
        if (mem_hold_i || dbg_halt_i) begin
            hold_o = PIPE;
        end
    end

    // a redirect only needs the fetched instruction thrown away
    assign flush_o     = jump_i | dbg_reset_pc_i;
    assign jump_o      = jump_i;
    assign jump_addr_o = jump_addr_i;

endmodule

// ==== pc_reg.sv ====
module pc_reg
    import tinyriscv_pkg::*;
(
    input  logic  clk_i,
    input  logic  arst_n_i,
    input  hold_e hold_i,
    input  logic  jump_i,
    input  addr_t jump_addr_i,
    input  logic  dbg_reset_pc_i,
    output addr_t pc_o
);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_o <= RESET_PC;
        end else if (dbg_reset_pc_i) begin
            pc_o <= RESET_PC;     // debugger restart
        end else if (jump_i) begin
            pc_o <= jump_addr_i;
        end else if (hold_i inside {PC, PIPE}) begin
            pc_o <= pc_o;         // stalled
        end else begin
            pc_o <= pc_o + 32'd4;
        end
    end

endmodule

// ==== tinyriscv_pkg.sv ====
package tinyriscv_pkg;

    typedef logic [31:0] inst_t;      // raw instruction word
    typedef logic [31:0] addr_t;      // byte address, fetch and data
    typedef logic [31:0] reg_t;       // general register value
    typedef logic [4:0]  reg_addr_t;  // x0..x31
    typedef logic [6:0]  opcode_t;

    localparam addr_t RESET_PC = 32'h0000_0000;
    localparam inst_t NOP_INST = 32'h0000_0013;  // addi x0, x0, 0

    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_OPIMM  = 7'b0010011;
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_JAL    = 7'b1101111;

    typedef enum logic [2:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLT,
        PASS_B  // lui, operand b straight through
    } alu_op_e;

    // pipeline hold level, PIPE also freezes if_id
    typedef enum logic [1:0] {
        NONE,
        PC,
        PIPE
    } hold_e;

    typedef struct packed {
        inst_t inst;
        addr_t inst_addr;
        logic  valid;  // low for a bubble
    } fetch_s;

    typedef struct packed {
        addr_t     inst_addr;
        reg_t      op_a;
        reg_t      op_b;
        reg_t      store_data;
        addr_t     branch_tgt;
        reg_addr_t rd;
        logic      reg_we;
        alu_op_e   alu_op;
        logic      is_load;
        logic      is_store;
        logic      is_branch;
        logic      branch_ne;  // bne when set, beq otherwise
        logic      is_jal;
    } exec_s;

endpackage
